/* verilog/csi2_defs.svh */
// CSI-2 transmitter constants
// Lane count, sync byte, short packet data types and gap lengths
`ifndef CSI2_DEFS_SVH
`define CSI2_DEFS_SVH

// Data lanes of the D-PHY
`define CSI2_LANES      4

// Leader byte ahead of every packet
`define CSI2_SYNC_BYTE  8'hB8

// Short packet data types
`define CSI2_DT_FS      6'h00
`define CSI2_DT_FE      6'h01

// Idle cycles between packets
`define CSI2_PKT_GAP    8

// Idle cycles after Frame End
`define CSI2_FRAME_GAP  16

`endif

/* verilog/csi2_pkg.sv */
// Shared types of the CSI-2 transmitter
// Packet request, packet header, lane bus, frame settings and FSM states
`include "csi2_defs.svh"

package csi2_pkg;

   // One packet for the serializer
   typedef struct packed {
      logic        long_pkt;
      logic [1:0]  vc;
      logic [5:0]  dt;
      logic [15:0] wc_or_data;
      logic [6:0]  pad;
   } pkt_req_t;

   // Header bytes, b0 goes out on lane 0
   typedef struct packed {
      logic [7:0] b3;
      logic [7:0] b2;
      logic [7:0] b1;
      logic [7:0] b0;
   } pkt_hdr_t;

   // Lane 0 sits in the lowest byte
   typedef struct packed {
      logic [`CSI2_LANES-1:0]      valid;
      logic [`CSI2_LANES-1:0][7:0] data;
   } lane_bus_t;

   typedef struct packed {
      logic [1:0]  vc;
      logic [5:0]  dt;
      logic [15:0] wc;
      logic [15:0] num_lines;
   } frame_cfg_t;

   typedef enum logic [2:0] {
      SEQ_IDLE,
      SEQ_FS,
      SEQ_LINE,
      SEQ_FE,
      SEQ_GAP
   } seq_state_e;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_SYNC,
      TX_HDR,
      TX_PAY,
      TX_CRC
   } tx_state_e;

endpackage

/* verilog/csi2_frame_seq.sv */
// Frame and line sequencer
// Issues FS, one long packet per line and FE, with fixed gaps in between
`timescale 1ns/100ps
`include "csi2_defs.svh"

module csi2_frame_seq (
   input  logic                 dphy_active,
   input  logic                 rst_n_i,
   input  logic                 frame_start_i,
   input  csi2_pkg::frame_cfg_t frame_cfg_i,
   input  logic                 pkt_busy_i,
   output logic                 pkt_start_o,
   output csi2_pkg::pkt_req_t   pkt_req_o,
   output logic                 frame_busy_o
);

   csi2_pkg::seq_state_e state;
   logic [15:0]          line_cnt;
   logic [1:0]           fnum;
   logic [7:0]           gap_cnt;
   logic                 gap_act;
   logic                 busy_q;
   logic                 pkt_done;
   logic                 last_line;

   // Serializer has just released the lanes
   assign pkt_done  = busy_q & ~pkt_busy_i;
   assign last_line = (line_cnt == frame_cfg_i.num_lines);

   // ======================================
   // Packet issue FSM
   // ======================================
   always_ff @(posedge dphy_active or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state        <= csi2_pkg::SEQ_IDLE;
         pkt_start_o  <= 1'b0;
         pkt_req_o    <= '0;
         frame_busy_o <= 1'b0;
         fnum         <= 2'd1;
         line_cnt     <= '0;
         gap_cnt      <= '0;
         gap_act      <= 1'b0;
         busy_q       <= 1'b0;
      end else begin
         busy_q      <= pkt_busy_i;
         pkt_start_o <= 1'b0;
         case (state)
            csi2_pkg::SEQ_IDLE: begin
               if (frame_start_i) begin
                  frame_busy_o         <= 1'b1;
                  pkt_start_o          <= 1'b1;
                  pkt_req_o            <= '0;
                  pkt_req_o.vc         <= frame_cfg_i.vc;
                  pkt_req_o.dt         <= `CSI2_DT_FS;
                  pkt_req_o.wc_or_data <= {14'd0, fnum};
                  line_cnt             <= '0;
                  state                <= csi2_pkg::SEQ_FS;
               end
            end
            csi2_pkg::SEQ_GAP: begin
               if (gap_cnt == 8'd0) begin
                  frame_busy_o <= 1'b0;
                  state        <= csi2_pkg::SEQ_IDLE;
               end else begin
                  gap_cnt <= gap_cnt - 8'd1;
               end
            end
            default: begin
               // Packet in flight, then the gap behind it
               if (pkt_done && state == csi2_pkg::SEQ_FE) begin
                  gap_cnt <= 8'(`CSI2_FRAME_GAP - 2);
                  fnum    <= ~fnum;
                  state   <= csi2_pkg::SEQ_GAP;
               end else if (pkt_done) begin
                  gap_cnt <= 8'(`CSI2_PKT_GAP - 2);
                  gap_act <= 1'b1;
               end else if (gap_act && gap_cnt != 8'd0) begin
                  gap_cnt <= gap_cnt - 8'd1;
               end else if (gap_act) begin
                  gap_act      <= 1'b0;
                  pkt_start_o  <= 1'b1;
                  pkt_req_o.vc <= frame_cfg_i.vc;
                  if (last_line) begin
                     pkt_req_o.long_pkt   <= 1'b0;
                     pkt_req_o.dt         <= `CSI2_DT_FE;
                     pkt_req_o.wc_or_data <= {14'd0, fnum};
                     state                <= csi2_pkg::SEQ_FE;
                  end else begin
                     pkt_req_o.long_pkt   <= 1'b1;
                     pkt_req_o.dt         <= frame_cfg_i.dt;
                     pkt_req_o.wc_or_data <= frame_cfg_i.wc;
                     line_cnt             <= line_cnt + 16'd1;
                     state                <= csi2_pkg::SEQ_LINE;
                  end
               end
            end
         endcase
      end
   end

endmodule

/* verilog/csi2_hdr_ecc.sv */
// Packet header builder
// Maps a packet request to four header bytes with the 6-bit ECC in b3
`timescale 1ns/100ps

module csi2_hdr_ecc (
   input  csi2_pkg::pkt_req_t pkt_req_i,
   output csi2_pkg::pkt_hdr_t pkt_hdr_o
);

   // Parity masks over {b2, b1, b0}, one per ECC bit
   localparam logic [5:0][23:0] ECC_MASK = {
      24'hEFFC00,
      24'hDF03F0,
      24'hB8E38E,
      24'h749A6D,
      24'hF2555B,
      24'hF12CB7
   };

   logic [23:0] hdr_bits;
   logic [5:0]  ecc;

   // b0 = {vc, dt}, b1 and b2 = word count or frame number
   assign hdr_bits = {pkt_req_i.wc_or_data, pkt_req_i.vc, pkt_req_i.dt};

   always_comb begin
      for (int i = 0; i < 6; i++) begin
         ecc[i] = ^(hdr_bits & ECC_MASK[i]);
      end
   end

   // Top two bits of b3 stay zero
   assign pkt_hdr_o = {2'b00, ecc, hdr_bits};

endmodule

/* verilog/csi2_crc16.sv */
// Payload CRC-16
// Polynomial 0x8408, seed 0xFFFF, four bytes per cycle taken LSB first
`timescale 1ns/100ps

module csi2_crc16 (
   input  logic        dphy_active,
   input  logic        rst_n_i,
   input  logic        crc_clear_i,
   input  logic        crc_en_i,
   input  logic [31:0] crc_data_i,
   output logic [15:0] crc_o
);

   localparam logic [15:0] CRC_SEED = 16'hFFFF;
   localparam logic [15:0] CRC_POLY = 16'h8408;

   logic [15:0] crc_q;
   logic [15:0] crc_next;

   // 32 serial steps, lane 0 byte first
   always_comb begin
      crc_next = crc_q;
      for (int i = 0; i < 32; i++) begin
         if (crc_next[0] ^ crc_data_i[i]) begin
            crc_next = (crc_next >> 1) ^ CRC_POLY;
         end else begin
            crc_next = crc_next >> 1;
         end
      end
   end

   always_ff @(posedge dphy_active or negedge rst_n_i) begin
      if (!rst_n_i) begin
         crc_q <= CRC_SEED;
      end else if (crc_clear_i) begin
         crc_q <= CRC_SEED;
      end else if (crc_en_i) begin
         crc_q <= crc_next;
      end
   end

   assign crc_o = crc_q;

endmodule

/* verilog/csi2_lane_tx.sv */
// Four-lane packet serializer
// Puts sync, header, payload and CRC bytes onto the lanes
// Also holds the payload CRC
`timescale 1ns/100ps
`include "csi2_defs.svh"

module csi2_lane_tx (
   input  logic                dphy_active,
   input  logic                rst_n_i,
   input  logic                pkt_start_i,
   input  csi2_pkg::pkt_req_t  pkt_req_i,
   input  csi2_pkg::pkt_hdr_t  pkt_hdr_i,
   input  logic [31:0]         pay_data_i,
   output logic                pay_rd_o,
   output logic                pkt_busy_o,
   output csi2_pkg::lane_bus_t lanes_o
);

   csi2_pkg::tx_state_e state;
   csi2_pkg::pkt_hdr_t  hdr_q;
   logic                long_q;
   logic [13:0]         word_cnt;
   logic [15:0]         crc;
   logic                accept;

   assign accept = pkt_start_i & (state == csi2_pkg::TX_IDLE);

   // ======================================
   // Packet phases
   // ======================================
   always_ff @(posedge dphy_active or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state    <= csi2_pkg::TX_IDLE;
         long_q   <= 1'b0;
         word_cnt <= '0;
      end else begin
         case (state)
            csi2_pkg::TX_IDLE: begin
               if (accept) begin
                  long_q   <= pkt_req_i.long_pkt;
                  // wc / 4 payload words
                  word_cnt <= pkt_req_i.wc_or_data[15:2];
                  state    <= csi2_pkg::TX_SYNC;
               end
            end
            csi2_pkg::TX_SYNC: begin
               state <= csi2_pkg::TX_HDR;
            end
            csi2_pkg::TX_HDR: begin
               if (!long_q) begin
                  state <= csi2_pkg::TX_IDLE;
               end else if (word_cnt == 14'd0) begin
                  state <= csi2_pkg::TX_CRC;
               end else begin
                  state <= csi2_pkg::TX_PAY;
               end
            end
            csi2_pkg::TX_PAY: begin
               word_cnt <= word_cnt - 14'd1;
               if (word_cnt == 14'd1) begin
                  state <= csi2_pkg::TX_CRC;
               end
            end
            default: begin
               state <= csi2_pkg::TX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge dphy_active) begin
      if (accept) begin
         hdr_q <= pkt_hdr_i;
      end
   end

   csi2_crc16 crc_i (
      .dphy_active (dphy_active),
      .rst_n_i     (rst_n_i),
      .crc_clear_i (accept),
      .crc_en_i    (pay_rd_o),
      .crc_data_i  (pay_data_i),
      .crc_o       (crc)
   );

   // ======================================
   // Lane outputs
   // ======================================
   assign pay_rd_o   = (state == csi2_pkg::TX_PAY);
   assign pkt_busy_o = (state != csi2_pkg::TX_IDLE);

   always_comb begin
      lanes_o = '0;
      case (state)
         csi2_pkg::TX_SYNC: begin
            lanes_o.valid = '1;
            lanes_o.data  = {`CSI2_LANES{`CSI2_SYNC_BYTE}};
         end
         csi2_pkg::TX_HDR: begin
            lanes_o.valid = '1;
            lanes_o.data  = hdr_q;
         end
         csi2_pkg::TX_PAY: begin
            lanes_o.valid = '1;
            lanes_o.data  = pay_data_i;
         end
         csi2_pkg::TX_CRC: begin
            // CRC on lanes 0 and 1 only
            lanes_o.valid   = 4'b0011;
            lanes_o.data[0] = crc[7:0];
            lanes_o.data[1] = crc[15:8];
         end
         default: begin
            lanes_o = '0;
         end
      endcase
   end

endmodule

/* verilog/csi2_tx_top.sv */
// CSI-2 transmitter top level
// Sequencer, header builder and four-lane serializer
`timescale 1ns/100ps

module csi2_tx_top (
   input  logic                 dphy_active,
   input  logic                 rst_n_i,
   input  logic                 frame_start_i,
   input  csi2_pkg::frame_cfg_t frame_cfg_i,
   input  logic [31:0]          pay_data_i,
   output logic                 pay_rd_o,
   output csi2_pkg::lane_bus_t  lanes_o,
   output logic                 frame_busy_o
);

   csi2_pkg::pkt_req_t pkt_req;
   csi2_pkg::pkt_hdr_t pkt_hdr;
   logic               pkt_start;
   logic               pkt_busy;

   csi2_frame_seq seq_i (
      .dphy_active  (dphy_active),
      .rst_n_i      (rst_n_i),
      .frame_start_i(frame_start_i),
      .frame_cfg_i  (frame_cfg_i),
      .pkt_busy_i   (pkt_busy),
      .pkt_start_o  (pkt_start),
      .pkt_req_o    (pkt_req),
      .frame_busy_o (frame_busy_o)
   );

   csi2_hdr_ecc hdr_i (
      .pkt_req_i (pkt_req),
      .pkt_hdr_o (pkt_hdr)
   );

   csi2_lane_tx lane_i (
      .dphy_active (dphy_active),
      .rst_n_i     (rst_n_i),
      .pkt_start_i (pkt_start),
      .pkt_req_i   (pkt_req),
      .pkt_hdr_i   (pkt_hdr),
      .pay_data_i  (pay_data_i),
      .pay_rd_o    (pay_rd_o),
      .pkt_busy_o  (pkt_busy),
      .lanes_o     (lanes_o)
   );

endmodule

/* dv/tb_clk_gen.sv */
// Testbench clock and reset generator
// 10 ns clock, reset held low for the first 8 cycles
`timescale 1ns/100ps

module tb_clk_gen #(
   parameter int PERIOD_NS   = 10,
   parameter int RST_CYCLES  = 8
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

/* dv/csi2_tx_sva.sv */
// Bound assertions for the CSI-2 transmitter
// Lane valid patterns, payload reads, reset state, ignored frame starts
`timescale 1ns/100ps
`include "csi2_defs.svh"

module csi2_tx_sva (
   input logic                dphy_active,
   input logic                rst_n_i,
   input logic                frame_start_i,
   input logic                frame_busy_i,
   input logic                pay_rd_i,
   input csi2_pkg::lane_bus_t lanes_i,
   input logic                pkt_start_i,
   input csi2_pkg::pkt_req_t  pkt_req_i
);

   int fail_cnt = 0;

   a_valid_pattern: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      (lanes_i.valid == 4'h0 || lanes_i.valid == 4'h3 || lanes_i.valid == 4'hF))
      else begin
         $error("illegal lane valid pattern %b", lanes_i.valid);
         fail_cnt++;
      end

   a_read_in_frame: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      pay_rd_i |-> frame_busy_i)
      else begin
         $error("payload read outside a frame");
         fail_cnt++;
      end

   a_reset_quiet: assert property (@(posedge dphy_active)
      !rst_n_i |-> (lanes_i.valid == '0 && !pay_rd_i && !frame_busy_i))
      else begin
         $error("outputs active during reset");
         fail_cnt++;
      end

   // A start during a frame must not launch another Frame Start
   a_start_ignored: assert property (@(posedge dphy_active) disable iff (!rst_n_i)
      (frame_start_i && frame_busy_i) |=>
         !(pkt_start_i && !pkt_req_i.long_pkt && pkt_req_i.dt == `CSI2_DT_FS))
      else begin
         $error("frame start while busy produced a Frame Start packet");
         fail_cnt++;
      end

endmodule

/* dv/csi2_tx_tb.sv */
// Testbench for the CSI-2 transmitter
// Reads frames from the test data file, feeds payload, checks lanes, watchdog
`timescale 1ns/100ps
`include "csi2_defs.svh"

module csi2_tx_tb;

   localparam int MAX_FRAMES = 8;

   logic                 dphy_active;
   logic                 rst_n_i;
   logic                 frame_start_i;
   csi2_pkg::frame_cfg_t frame_cfg_i;
   logic [31:0]          pay_data_i;
   logic                 pay_rd_o;
   logic                 frame_busy_o;
   csi2_pkg::lane_bus_t  lanes_o;

   csi2_pkg::frame_cfg_t cfg_tab [MAX_FRAMES];
   logic [5:0]           fs_ecc [MAX_FRAMES];
   logic [5:0]           fe_ecc [MAX_FRAMES];
   logic [5:0]           long_ecc [MAX_FRAMES];
   logic [31:0]          pay_words [$];
   logic [15:0]          crc_tab [$];
   int                   n_frames = 0;
   int                   errors = 0;
   int                   pay_idx = 0;
   int                   exp_word = 0;
   int                   exp_crc = 0;
   longint               limit_cycles = 0;
   logic                 loaded = 1'b0;

   tb_clk_gen clk_gen_i (
      .clk_o   (dphy_active),
      .rst_n_o (rst_n_i)
   );

   csi2_tx_top dut_i (
      .dphy_active   (dphy_active),
      .rst_n_i       (rst_n_i),
      .frame_start_i (frame_start_i),
      .frame_cfg_i   (frame_cfg_i),
      .pay_data_i    (pay_data_i),
      .pay_rd_o      (pay_rd_o),
      .lanes_o       (lanes_o),
      .frame_busy_o  (frame_busy_o)
   );

   bind csi2_tx_top csi2_tx_sva sva_i (
      .dphy_active   (dphy_active),
      .rst_n_i       (rst_n_i),
      .frame_start_i (frame_start_i),
      .frame_busy_i  (frame_busy_o),
      .pay_rd_i      (pay_rd_o),
      .lanes_i       (lanes_o),
      .pkt_start_i   (pkt_start),
      .pkt_req_i     (pkt_req)
   );

   function automatic logic [31:0] word_at(int idx);
      if (idx < pay_words.size()) begin
         return pay_words[idx];
      end
      return 32'h0;
   endfunction

   task automatic load_testdata();
      int          fd;
      int          rc;
      string       line;
      logic [15:0] t_vc, t_dt, t_wc, t_nl, t_fs, t_fe, t_lg;
      logic [31:0] v;
      fd = $fopen("dv/csi2_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the test data file");
         errors++;
         return;
      end
      rc = $fgets(line, fd);
      rc = $fgets(line, fd);
      rc = $fscanf(fd, "%h", n_frames);
      for (int f = 0; f < n_frames; f++) begin
         rc = $fscanf(fd, "%h %h %h %h %h %h %h", t_vc, t_dt, t_wc, t_nl, t_fs, t_fe, t_lg);
         cfg_tab[f].vc        = t_vc[1:0];
         cfg_tab[f].dt        = t_dt[5:0];
         cfg_tab[f].wc        = t_wc;
         cfg_tab[f].num_lines = t_nl;
         fs_ecc[f]   = t_fs[5:0];
         fe_ecc[f]   = t_fe[5:0];
         long_ecc[f] = t_lg[5:0];
         for (int l = 0; l < t_nl; l++) begin
            for (int w = 0; w < t_wc / 4; w++) begin
               rc = $fscanf(fd, "%h", v);
               pay_words.push_back(v);
            end
            rc = $fscanf(fd, "%h", v);
            crc_tab.push_back(v[15:0]);
         end
         limit_cycles += t_nl * (t_wc / 4 + 3 + `CSI2_PKT_GAP)
                         + 2 * (2 + `CSI2_PKT_GAP) + `CSI2_FRAME_GAP;
      end
      $fclose(fd);
      limit_cycles = limit_cycles * 2 + 100;
   endtask

   task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   // Waits for the sync cycle of the next packet and checks it
   task automatic expect_sync(string name);
      int n;
      n = 0;
      @(negedge dphy_active);
      while (lanes_o.valid == '0 && n < 64) begin
         @(negedge dphy_active);
         n++;
      end
      if (lanes_o.valid == '0) begin
         $display("%s: no packet appeared on the lanes", name);
         errors++;
      end
      compare({name, " sync valid"}, 32'hF, lanes_o.valid);
      compare({name, " sync"}, {`CSI2_LANES{`CSI2_SYNC_BYTE}}, lanes_o.data);
   endtask

   task automatic check_short(string name, int f, logic [5:0] dt, logic [5:0] ecc,
                              logic [1:0] fnum);
      expect_sync(name);
      @(negedge dphy_active);
      compare({name, " hdr valid"}, 32'hF, lanes_o.valid);
      compare({name, " hdr"}, {2'b00, ecc, 8'h00, 6'd0, fnum, cfg_tab[f].vc, dt},
              lanes_o.data);
   endtask

   task automatic check_long(string name, int f);
      expect_sync(name);
      @(negedge dphy_active);
      compare({name, " hdr valid"}, 32'hF, lanes_o.valid);
      compare({name, " hdr"},
              {2'b00, long_ecc[f], cfg_tab[f].wc, cfg_tab[f].vc, cfg_tab[f].dt},
              lanes_o.data);
      compare({name, " hdr pay_rd"}, 32'h0, pay_rd_o);
      for (int w = 0; w < cfg_tab[f].wc / 4; w++) begin
         @(negedge dphy_active);
         compare({name, " payload valid"}, 32'hF, lanes_o.valid);
         compare({name, " payload"}, word_at(exp_word), lanes_o.data);
         compare({name, " payload pay_rd"}, 32'h1, pay_rd_o);
         exp_word++;
      end
      @(negedge dphy_active);
      compare({name, " crc valid"}, 32'h3, lanes_o.valid);
      compare({name, " crc"}, crc_tab[exp_crc], lanes_o.data[15:0]);
      compare({name, " crc pay_rd"}, 32'h0, pay_rd_o);
      exp_crc++;
   endtask

   // Payload source, show-ahead style
   always @(posedge dphy_active) begin
      if (pay_rd_o) begin
         pay_idx    <= pay_idx + 1;
         pay_data_i <= word_at(pay_idx + 1);
      end
   end

   initial begin
      wait (loaded);
      #(limit_cycles * 10);
      $display("Watchdog expired before the tests finished");
      $display("Something failed");
      $finish;
   end

   initial begin
      logic [1:0] fnum;
      int         n;
      frame_start_i <= 1'b0;
      frame_cfg_i   <= '0;
      pay_data_i    <= '0;
      load_testdata();
      loaded = 1'b1;
      fnum = 2'd1;
      @(posedge rst_n_i);
      @(posedge dphy_active);
      pay_data_i <= word_at(0);
      for (int f = 0; f < n_frames; f++) begin
         @(posedge dphy_active);
         frame_cfg_i   <= cfg_tab[f];
         frame_start_i <= 1'b1;
         @(posedge dphy_active);
         frame_start_i <= 1'b0;
         check_short($sformatf("frame%0d FS", f), f, `CSI2_DT_FS, fs_ecc[f], fnum);
         // Start pulse during the frame, to be ignored
         @(posedge dphy_active);
         frame_start_i <= 1'b1;
         @(posedge dphy_active);
         frame_start_i <= 1'b0;
         for (int l = 0; l < cfg_tab[f].num_lines; l++) begin
            check_long($sformatf("frame%0d line%0d", f, l), f);
         end
         check_short($sformatf("frame%0d FE", f), f, `CSI2_DT_FE, fe_ecc[f], fnum);
         n = 0;
         while (frame_busy_o && n < 2 * `CSI2_FRAME_GAP) begin
            @(negedge dphy_active);
            compare($sformatf("frame%0d gap valid", f), 32'h0, lanes_o.valid);
            n++;
         end
         if (frame_busy_o) begin
            $display("frame%0d: frame_busy_o did not fall after Frame End", f);
            errors++;
         end
         fnum = (fnum == 2'd1) ? 2'd2 : 2'd1;
      end
      errors += dut_i.sva_i.fail_cnt;
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* dv/csi2_testdata.txt */
# frame count, then per frame: vc dt wc lines fs_ecc fe_ecc long_ecc (hex)
# then per line: wc/4 payload words followed by the expected crc (hex)
2
0 2b 0004 0002 1a 1d 34
ffffffff f0b8
0000ffff 0000
1 2b 0008 0001 0a 0d 24
0000ffff 00000000 0000

/* src.f */
+incdir+verilog
verilog/csi2_pkg.sv
verilog/csi2_frame_seq.sv
verilog/csi2_hdr_ecc.sv
verilog/csi2_crc16.sv
verilog/csi2_lane_tx.sv
verilog/csi2_tx_top.sv
dv/tb_clk_gen.sv
dv/csi2_tx_sva.sv
dv/csi2_tx_tb.sv
